//--- compile.f
+incdir+hw
+incdir+testbench
hw/mbxPkg.sv
hw/mbxCycleDecode.sv
hw/mbWordTracker.sv
hw/cacheToMbSequencer.sv
hw/mbxControl.sv
testbench/mbxControlTb.sv

//--- hw/cacheToMbSequencer.sv
`timescale 1ns/1ps

module cacheToMbSequencer (
  input  logic             clk,
  input  logic             rstN,
  input  logic             wbStart,
  input  mbxPkg::wordMaskT wbMask,
  input  logic             phaseChange,
  output mbxPkg::mbLoadT   cacheLoad,
  output logic             transferDone
);

  import mbxPkg::*;

  ctombStateE state;
  ctombStateE stateNext;
  wordMaskT   remaining;
  wordMaskT   remainingNext;
  wordAdrT    loadAdr;

  // Words go out lowest first
  assign loadAdr = lowestWord(remaining);

  ////////////////////////////////////////
  // T1..T4 phase chain

  always_comb begin
    stateNext = state;
    remainingNext = remaining;
    cacheLoad = '0;
    transferDone = 1'b0;
    case (state)
      ctombIdle: begin
        if (wbStart) begin
          stateNext = ctombT1;
          remainingNext = wbMask;
        end
      end
      ctombT1: begin
        stateNext = ctombT2;
      end
      ctombT2: begin
        // Hold until memory signals the phase boundary
        if (phaseChange) begin
          stateNext = ctombT3;
        end
      end
      ctombT3: begin
        stateNext = ctombT4;
      end
      ctombT4: begin
        cacheLoad.load = 1'b1;
        cacheLoad.wordAdr = loadAdr;
        remainingNext = remaining & ~wordOneHot(loadAdr);
        if (|remainingNext) begin
          stateNext = ctombT1;
        end else begin
          stateNext = ctombIdle;
          transferDone = 1'b1;
        end
      end
      default: begin
        stateNext = ctombIdle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= ctombIdle;
      remaining <= '0;
    end else begin
      state <= stateNext;
      remaining <= remainingNext;
    end
  end

  ////////////////////////////////////////
  // Checks

  startWhileBusy: assert property (
    @(posedge clk) disable iff (!rstN)
    wbStart |-> state == ctombIdle
  );

  // Every load is the T4 that closes a full T3 pass
  loadOnlyInT4: assert property (
    @(posedge clk) disable iff (!rstN)
    cacheLoad.load |-> (state == ctombT4) && ($past(state) == ctombT3)
  );

endmodule

//--- hw/mbWordTracker.sv
`timescale 1ns/1ps

module mbWordTracker (
  input  logic            clk,
  input  logic            rstN,
  input  mbxPkg::mbLoadT  coreStore,
  input  mbxPkg::mbLoadT  cacheLoad,
  input  logic            memAck,
  output mbxPkg::wordAdrT mbSel,
  output logic            mbReqHold
);

  import mbxPkg::*;

  wordMaskT pending;
  wordMaskT pendingNext;
  wordMaskT setMask;
  wordMaskT clrMask;

  ////////////////////////////////////////
  // Set and clear of request bits

  always_comb begin
    setMask = '0;
    if (coreStore.load) begin
      setMask = setMask | wordOneHot(coreStore.wordAdr);
    end
    if (cacheLoad.load) begin
      setMask = setMask | wordOneHot(cacheLoad.wordAdr);
    end
  end

  // Ack retires the word memory is working on
  always_comb begin
    clrMask = '0;
    if (memAck) begin
      clrMask = wordOneHot(mbSel);
    end
  end

  // Load on the acked word keeps it pending
  assign pendingNext = (pending & ~clrMask) | setMask;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pending <= '0;
    end else begin
      pending <= pendingNext;
    end
  end

  ////////////////////////////////////////
  // Priority select

  assign mbSel = lowestWord(pending);
  assign mbReqHold = |pending;

  ////////////////////////////////////////
  // Checks

  ackWithoutHold: assert property (
    @(posedge clk) disable iff (!rstN)
    memAck |-> mbReqHold
  );

endmodule

//--- hw/mbxControl.sv
`timescale 1ns/1ps

module mbxControl (
  input  logic             clk,
  input  logic             rstN,
  input  logic             cycleStrobe,
  input  mbxPkg::cycleReqT cycleReq,
  input  mbxPkg::mbLoadT   coreStore,
  input  logic             memAck,
  input  logic             phaseChange,
  output logic             memReqStrobe,
  output mbxPkg::memReqT   memReq,
  output mbxPkg::wordAdrT  mbSel,
  output logic             mbReqHold,
  output logic             transferDone
);

  import mbxPkg::*;

  logic     wbStart;
  wordMaskT wbMask;
  mbLoadT   cacheLoad;

  ////////////////////////////////////////
  // Cycle decode

  mbxCycleDecode decode (
    .clk          (clk),
    .rstN         (rstN),
    .cycleStrobe  (cycleStrobe),
    .cycleReq     (cycleReq),
    .memReqStrobe (memReqStrobe),
    .memReq       (memReq),
    .wbStart      (wbStart),
    .wbMask       (wbMask)
  );

  ////////////////////////////////////////
  // Writeback into the MB

  cacheToMbSequencer ctomb (
    .clk          (clk),
    .rstN         (rstN),
    .wbStart      (wbStart),
    .wbMask       (wbMask),
    .phaseChange  (phaseChange),
    .cacheLoad    (cacheLoad),
    .transferDone (transferDone)
  );

  ////////////////////////////////////////
  // MB write requests

  mbWordTracker tracker (
    .clk       (clk),
    .rstN      (rstN),
    .coreStore (coreStore),
    .cacheLoad (cacheLoad),
    .memAck    (memAck),
    .mbSel     (mbSel),
    .mbReqHold (mbReqHold)
  );

endmodule

//--- hw/mbxCycleDecode.sv
`timescale 1ns/1ps

module mbxCycleDecode (
  input  logic             clk,
  input  logic             rstN,
  input  logic             cycleStrobe,
  input  mbxPkg::cycleReqT cycleReq,
  output logic             memReqStrobe,
  output mbxPkg::memReqT   memReq,
  output logic             wbStart,
  output mbxPkg::wordMaskT wbMask
);

  import mbxPkg::*;

  memReqT memReqNext;
  logic   wbNext;
  logic   knownCyc;

  ////////////////////////////////////////
  // Cycle classification

  always_comb begin
    memReqNext = '0;
    wbNext = 1'b0;
    knownCyc = 1'b1;
    case (cycleReq.cycType)
      cycCoreRead, cycPageRefill: begin
        // Fetch only the words the cache lacks
        memReqNext.rdReq = 1'b1;
        memReqNext.rqMask = ~cycleReq.wordValid;
      end
      cycOneWordRead: begin
        memReqNext.rdReq = 1'b1;
        memReqNext.rqMask = wordOneHot(cycleReq.wordAdr);
      end
      cycOneWordWrite: begin
        memReqNext.wrReq = 1'b1;
        memReqNext.rqMask = wordOneHot(cycleReq.wordAdr);
      end
      cycWriteback: begin
        memReqNext.wrReq = 1'b1;
        memReqNext.rqMask = cycleReq.wordValid;
        wbNext = 1'b1;
      end
      default: begin
        knownCyc = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Registered request

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memReqStrobe <= 1'b0;
      wbStart <= 1'b0;
    end else begin
      // Empty mask means nothing to ask of memory
      memReqStrobe <= cycleStrobe && (|memReqNext.rqMask);
      wbStart <= cycleStrobe && wbNext && (|cycleReq.wordValid);
    end
  end

  always_ff @(posedge clk) begin
    if (cycleStrobe) begin
      memReq <= memReqNext;
      wbMask <= cycleReq.wordValid;
    end
  end

  ////////////////////////////////////////
  // Checks

  unknownCycle: assert property (
    @(posedge clk) disable iff (!rstN)
    cycleStrobe |-> knownCyc
  );

endmodule

//--- hw/mbxPkg.sv
`include "mbx_settings.svh"

package mbxPkg;

  typedef logic [`MBX_WORDS-1:0] wordMaskT;
  typedef logic [`MBX_WORD_ADR_W-1:0] wordAdrT;
  typedef logic [2:0] cycTypeT;

  localparam cycTypeT cycCoreRead     = 3'd0;
  localparam cycTypeT cycOneWordRead  = 3'd1;
  localparam cycTypeT cycOneWordWrite = 3'd2;
  localparam cycTypeT cycPageRefill   = 3'd3;
  localparam cycTypeT cycWriteback    = 3'd4;

  typedef struct packed {
    cycTypeT cycType;
    wordAdrT wordAdr;
    wordMaskT wordValid;
  } cycleReqT;

  typedef struct packed {
    logic rdReq;
    logic wrReq;
    wordMaskT rqMask;
  } memReqT;

  typedef struct packed {
    logic load;
    wordAdrT wordAdr;
  } mbLoadT;

  typedef enum logic [2:0] {
    ctombIdle,
    ctombT1,
    ctombT2,
    ctombT3,
    ctombT4
  } ctombStateE;

  function automatic wordMaskT wordOneHot(wordAdrT adr);
    return wordMaskT'(1) << adr;
  endfunction

  // Lowest set word wins and an empty mask gives 0
  function automatic wordAdrT lowestWord(wordMaskT mask);
    wordAdrT adr;
    adr = '0;
    for (int i = `MBX_WORDS - 1; i >= 0; i--) begin
      if (mask[i]) begin
        adr = wordAdrT'(i);
      end
    end
    return adr;
  endfunction

endpackage

//--- hw/mbx_settings.svh
`ifndef MBX_SETTINGS_SVH
`define MBX_SETTINGS_SVH

// Words per cache line and per MB
`define MBX_WORDS 4

// Word address within the line
`define MBX_WORD_ADR_W 2

`endif

//--- run.sh
#!/bin/sh
# Build and run the mbxControl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f compile.f --top-module mbxControlTb -Mdir build
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./build/VmbxControlTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

if ! grep -q "Errors:" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi

exit 0

//--- testbench/mbxTbTable.svh
localparam int numRows = 21;

// Each row holds cycle type, word address and valid mask
// and then the expected strobe, rdReq, wrReq and rqMask
localparam decodeRowT decodeTable [numRows] = '{
  // Core read fetches the words missing from the cache
  '{cycCoreRead,     2'd0, 4'b0000, 1'b1, 1'b1, 1'b0, 4'b1111},
  '{cycCoreRead,     2'd0, 4'b1010, 1'b1, 1'b1, 1'b0, 4'b0101},
  '{cycCoreRead,     2'd2, 4'b0001, 1'b1, 1'b1, 1'b0, 4'b1110},
  '{cycCoreRead,     2'd1, 4'b0111, 1'b1, 1'b1, 1'b0, 4'b1000},
  '{cycCoreRead,     2'd0, 4'b1111, 1'b0, 1'b1, 1'b0, 4'b0000},

  // Page refill
  '{cycPageRefill,   2'd0, 4'b0110, 1'b1, 1'b1, 1'b0, 4'b1001},
  '{cycPageRefill,   2'd3, 4'b0000, 1'b1, 1'b1, 1'b0, 4'b1111},
  '{cycPageRefill,   2'd0, 4'b1100, 1'b1, 1'b1, 1'b0, 4'b0011},
  '{cycPageRefill,   2'd1, 4'b1111, 1'b0, 1'b1, 1'b0, 4'b0000},

  // Single words follow the address, whatever is valid
  '{cycOneWordRead,  2'd0, 4'b1111, 1'b1, 1'b1, 1'b0, 4'b0001},
  '{cycOneWordRead,  2'd1, 4'b0000, 1'b1, 1'b1, 1'b0, 4'b0010},
  '{cycOneWordRead,  2'd2, 4'b0101, 1'b1, 1'b1, 1'b0, 4'b0100},
  '{cycOneWordRead,  2'd3, 4'b1000, 1'b1, 1'b1, 1'b0, 4'b1000},
  '{cycOneWordWrite, 2'd0, 4'b0000, 1'b1, 1'b0, 1'b1, 4'b0001},
  '{cycOneWordWrite, 2'd1, 4'b1111, 1'b1, 1'b0, 1'b1, 4'b0010},
  '{cycOneWordWrite, 2'd2, 4'b0011, 1'b1, 1'b0, 1'b1, 4'b0100},
  '{cycOneWordWrite, 2'd3, 4'b0000, 1'b1, 1'b0, 1'b1, 4'b1000},

  // Writeback writes the valid words and starts a transfer
  '{cycWriteback,    2'd0, 4'b1011, 1'b1, 1'b0, 1'b1, 4'b1011},
  '{cycWriteback,    2'd2, 4'b0001, 1'b1, 1'b0, 1'b1, 4'b0001},
  '{cycWriteback,    2'd0, 4'b0000, 1'b0, 1'b0, 1'b1, 4'b0000},
  '{cycWriteback,    2'd1, 4'b1111, 1'b1, 1'b0, 1'b1, 4'b1111}
};

//--- testbench/mbxControlTb.sv
`timescale 1ns/1ps
`include "mbx_settings.svh"

module mbxControlTb;

  import mbxPkg::*;

  typedef struct packed {
    cycTypeT  cycType;
    wordAdrT  wordAdr;
    wordMaskT wordValid;
    logic     expStrobe;
    logic     expRd;
    logic     expWr;
    wordMaskT expMask;
  } decodeRowT;

  `include "mbxTbTable.svh"

  localparam logic [15:0] lfsrSeed = 16'd53832;
  localparam int numWbTests = 12;
  localparam int numRandCycles = 200;
  // Four words of T1, T2 (up to 4), T3 and T4
  localparam int wbWorstCycles = 4 * 8;
  localparam int wbTestCycles = wbWorstCycles + 16;
  // The extra 4 transfers are the writeback rows of the table
  localparam int timeoutCycles = numRows * 8 + (numWbTests + 4) * wbTestCycles
    + numRandCycles + 100;

  logic     clk;
  logic     rstN;
  logic     cycleStrobe;
  cycleReqT cycleReq;
  mbLoadT   coreStore;
  logic     memAck;
  logic     phaseChange;
  logic     memReqStrobe;
  memReqT   memReq;
  wordAdrT  mbSel;
  logic     mbReqHold;
  logic     transferDone;

  logic [15:0] lfsr;
  logic [7:0]  rnd;
  logic        randStore;
  logic        randAck;
  wordAdrT     randAdr;
  wordMaskT    modelPending;
  decodeRowT   wbRow;
  int          cycleCount;
  int          resetErrors;
  int          decodeErrors;
  int          trackErrors;
  int          wbErrors;

  mbxControl dut (
    .clk          (clk),
    .rstN         (rstN),
    .cycleStrobe  (cycleStrobe),
    .cycleReq     (cycleReq),
    .coreStore    (coreStore),
    .memAck       (memAck),
    .phaseChange  (phaseChange),
    .memReqStrobe (memReqStrobe),
    .memReq       (memReq),
    .mbSel        (mbSel),
    .mbReqHold    (mbReqHold),
    .transferDone (transferDone)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  ////////////////////////////////////////
  // Random bits and reference model

  function automatic logic [15:0] lfsrStep(logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  task automatic takeRandom(input int n, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      value = {value[6:0], lfsr[0]};
    end
  endtask

  function automatic wordMaskT wordBit(wordAdrT adr);
    wordMaskT m;
    m = '0;
    m[adr] = 1'b1;
    return m;
  endfunction

  // Lowest pending word or 0 when nothing waits
  function automatic wordAdrT firstPending(wordMaskT m);
    wordAdrT adr;
    logic    found;
    adr = '0;
    found = 1'b0;
    for (int i = 0; i < `MBX_WORDS; i++) begin
      if (m[i] && !found) begin
        adr = wordAdrT'(i);
        found = 1'b1;
      end
    end
    return adr;
  endfunction

  task automatic checkTracker();
    assert (mbSel == firstPending(modelPending) && mbReqHold == (modelPending != '0))
      else begin
        trackErrors++;
        $display("FAIL %0t: mbSel %0d hold %0b, model pending %b", $time, mbSel,
          mbReqHold, modelPending);
      end
  endtask

  // One clock of core store and ack, then model update and compare
  task automatic trackCycle(input logic store, input wordAdrT adr, input logic ack);
    wordMaskT clr;
    wordMaskT set;
    clr = '0;
    set = '0;
    coreStore.load = store;
    coreStore.wordAdr = adr;
    memAck = ack;
    @(posedge clk);
    #1;
    coreStore = '0;
    memAck = 1'b0;
    if (ack) begin
      clr = wordBit(firstPending(modelPending));
    end
    if (store) begin
      set = wordBit(adr);
    end
    modelPending = (modelPending & ~clr) | set;
    checkTracker();
  endtask

  ////////////////////////////////////////
  // Writeback and decode

  task automatic finishTransfer(input wordMaskT mask);
    logic [1:0] gapLeft;
    logic [7:0] r;
    int         doneCount;
    int         waited;
    gapLeft = 2'd0;
    doneCount = 0;
    waited = 0;
    while (doneCount == 0 && waited < wbWorstCycles) begin
      // Phase boundary every 1 to 4 cycles
      phaseChange = (gapLeft == 2'd0);
      if (gapLeft == 2'd0) begin
        takeRandom(2, r);
        gapLeft = r[1:0];
      end else begin
        gapLeft = gapLeft - 2'd1;
      end
      @(posedge clk);
      #1;
      waited++;
      if (transferDone) begin
        doneCount++;
      end
    end
    phaseChange = 1'b0;
    repeat (3) begin
      @(posedge clk);
      #1;
      if (transferDone) begin
        doneCount++;
      end
    end
    assert (doneCount == 1)
      else begin
        wbErrors++;
        $display("FAIL %0t: %0d transfer done pulses for mask %b", $time, doneCount, mask);
      end
    modelPending = mask;
    checkTracker();
    while (modelPending != '0) begin
      trackCycle(1'b0, 2'd0, 1'b1);
    end
  endtask

  task automatic applyRow(input decodeRowT row);
    cycleStrobe = 1'b1;
    cycleReq.cycType = row.cycType;
    cycleReq.wordAdr = row.wordAdr;
    cycleReq.wordValid = row.wordValid;
    @(posedge clk);
    #1;
    cycleStrobe = 1'b0;
    assert (memReqStrobe == row.expStrobe)
      else begin
        decodeErrors++;
        $display("FAIL %0t: cycle %0d valid %b strobe %0b", $time, row.cycType,
          row.wordValid, memReqStrobe);
      end
    if (row.expStrobe) begin
      assert (memReq.rdReq == row.expRd && memReq.wrReq == row.expWr
        && memReq.rqMask == row.expMask)
        else begin
          decodeErrors++;
          $display("FAIL %0t: cycle %0d got rd %0b wr %0b mask %b", $time, row.cycType,
            memReq.rdReq, memReq.wrReq, memReq.rqMask);
        end
    end
    @(posedge clk);
    #1;
    assert (!memReqStrobe)
      else begin
        decodeErrors++;
        $display("FAIL %0t: memReqStrobe longer than one cycle", $time);
      end
    if (row.cycType == cycWriteback && row.wordValid != '0) begin
      finishTransfer(row.wordValid);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence

  initial begin
    rstN = 1'b0;
    cycleStrobe = 1'b0;
    cycleReq = '0;
    coreStore = '0;
    memAck = 1'b0;
    phaseChange = 1'b0;
    modelPending = '0;
    lfsr = lfsrSeed;
    resetErrors = 0;
    decodeErrors = 0;
    trackErrors = 0;
    wbErrors = 0;
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;
    assert (!memReqStrobe && !mbReqHold && !transferDone && mbSel == '0)
      else begin
        resetErrors++;
        $display("FAIL %0t: outputs not clear after reset", $time);
      end

    for (int i = 0; i < numRows; i++) begin
      applyRow(decodeTable[i]);
    end

    // Stores go in out of order and acks drain them lowest first
    trackCycle(1'b1, 2'd3, 1'b0);
    trackCycle(1'b1, 2'd1, 1'b0);
    trackCycle(1'b1, 2'd2, 1'b0);
    trackCycle(1'b1, 2'd0, 1'b0);
    while (modelPending != '0) begin
      trackCycle(1'b0, 2'd0, 1'b1);
    end

    for (int n = 0; n < numWbTests; n++) begin
      takeRandom(4, rnd);
      wbRow.wordValid = (rnd[3:0] == 4'b0000) ? 4'b1000 : rnd[3:0];
      takeRandom(2, rnd);
      wbRow.wordAdr = rnd[1:0];
      wbRow.cycType = cycWriteback;
      wbRow.expStrobe = 1'b1;
      wbRow.expRd = 1'b0;
      wbRow.expWr = 1'b1;
      wbRow.expMask = wbRow.wordValid;
      applyRow(wbRow);
    end

    for (int n = 0; n < numRandCycles; n++) begin
      takeRandom(1, rnd);
      randStore = rnd[0];
      takeRandom(2, rnd);
      randAdr = rnd[1:0];
      takeRandom(1, rnd);
      randAck = rnd[0] && (modelPending != '0);
      takeRandom(1, rnd);
      // Load onto the word being acked
      if (randAck && rnd[0]) begin
        randStore = 1'b1;
        randAdr = firstPending(modelPending);
      end
      trackCycle(randStore, randAdr, randAck);
    end
    while (modelPending != '0) begin
      trackCycle(1'b0, 2'd0, 1'b1);
    end

    $display("Errors: reset %0d, decode %0d, tracker %0d, writeback %0d", resetErrors,
      decodeErrors, trackErrors, wbErrors);
    if (resetErrors + decodeErrors + trackErrors + wbErrors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule
